//--- source/mem_net_config.svh
/* build-time widths and address map for the memory network slice
   bank split and secure base are byte addresses; words are 4 bytes */

`ifndef MEM_NET_CONFIG_SVH
`define MEM_NET_CONFIG_SVH

// ====================
// message widths
// ====================
`define MEM_ADDR_NBITS 32
`define MEM_DATA_NBITS 32
`define MEM_OPAQUE_NBITS 8
// also the number of opaque high bits that carry the source core id
`define NET_SRCDEST_NBITS 3

// ====================
// address map
// ====================
// word index is addr[9:2], so this must stay 256 for that slice
`define BANK_WORDS 256
`define INST_BANK_LIMIT 32'h0000_4000
`define DATA_BANK_LIMIT 32'h0000_C000
`define SECURE_BASE 32'h0000_8000
// 1 sends every non-dirmem request to bank 0
`define SINGLE_BANK 0

`endif

//--- source/mem_msg_pkg.sv
/* memory-side message types; single-word accesses only, no length field
   opaque high bits are overwritten by the network with the source core id */

`include "mem_net_config.svh"

package mem_msg_pkg;

  // request opcodes
  // dirmem reads like rd but is always routed to bank 1
  typedef enum logic [1:0] {
    mem_rd     = 2'd0,
    mem_wr     = 2'd1,
    mem_dirmem = 2'd2
  } mem_op_e;

  // control part of a request, data travels on its own lane
  typedef struct packed {
    mem_op_e                      op;
    logic [`MEM_OPAQUE_NBITS-1:0] opaque;
    logic [`MEM_ADDR_NBITS-1:0]   addr;
    // 1 = secure domain
    logic                         domain;
  } mem_req_ctrl_t;

  // control part of a response
  // domain and fail sit above op and opaque, as on the wire
  typedef struct packed {
    logic                         domain;
    logic                         fail;
    mem_op_e                      op;
    logic [`MEM_OPAQUE_NBITS-1:0] opaque;
  } mem_resp_ctrl_t;

endpackage

//--- source/net_msg_pkg.sv
/* network-side types; one header layout serves both directions
   payload is sized for the larger (request) control struct */

`include "mem_net_config.svh"

package net_msg_pkg;

  // payload width covers both memory control structs
  localparam int unsigned req_payload_nbits  = $bits(mem_msg_pkg::mem_req_ctrl_t);
  localparam int unsigned resp_payload_nbits = $bits(mem_msg_pkg::mem_resp_ctrl_t);
  localparam int unsigned payload_nbits =
    (req_payload_nbits > resp_payload_nbits) ? req_payload_nbits : resp_payload_nbits;

  // control part of a split network message
  // the memory control struct sits in the low payload bits, upper bits zero
  typedef struct packed {
    logic [`NET_SRCDEST_NBITS-1:0] dest;
    logic [`NET_SRCDEST_NBITS-1:0] src;
    logic [payload_nbits-1:0]      payload;
  } net_hdr_t;

  // sequencer states, one request in flight
  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_access,
    st_respond,
    st_release
  } ctrl_state_e;

endpackage

//--- source/net_chan_if.sv
/* one split network channel: header, data lane and load flag
   load is driven by the sender and tells the receiver the message is usable */

`timescale 1ns/1ps

`include "mem_net_config.svh"

interface net_chan_if;

  // control part
  net_msg_pkg::net_hdr_t       hdr;
  // data part
  logic [`MEM_DATA_NBITS-1:0]  data;
  // sender-side flag, meaning depends on the channel
  logic                        load;

  // sender side
  modport src (
    output hdr,
    output data,
    output load
  );

  // receiver side
  modport dst (
    input hdr,
    input data,
    input load
  );

endinterface

//--- source/mem_req_to_net.sv
/* combinational request adapter; net_src must fit in NET_SRCDEST_NBITS
   the opaque high bits of the request are lost, only the low bits come back */

`timescale 1ns/1ps

`include "mem_net_config.svh"

module mem_req_to_net #(
  parameter int net_src = 0
) (
  // 0 = instruction side, 1 = data side
  input  logic                         mode,
  input  mem_msg_pkg::mem_op_e         req_op,
  input  logic [`MEM_OPAQUE_NBITS-1:0] req_opaque,
  input  logic [`MEM_ADDR_NBITS-1:0]   req_addr,
  input  logic [`MEM_DATA_NBITS-1:0]   req_data,
  input  logic                         req_domain,
  net_chan_if.src                      chan
);

  localparam int ns = `NET_SRCDEST_NBITS;
  localparam int mo = `MEM_OPAQUE_NBITS;
  localparam logic [ns-1:0] src_id = ns'(net_src);
  localparam bit single_bank = (`SINGLE_BANK != 0);

  logic [ns-1:0]                          dest;
  logic [`MEM_ADDR_NBITS-1:0]             bank_limit;
  mem_msg_pkg::mem_req_ctrl_t             ctrl;
  logic [net_msg_pkg::payload_nbits-1:0]  payload;

  // ====================
  // bank routing
  // ====================
  // split point depends on which side of the core is asking
  assign bank_limit = mode ? `DATA_BANK_LIMIT : `INST_BANK_LIMIT;

  always_comb begin
    if (req_op == mem_msg_pkg::mem_dirmem) begin
      // direct memory always lives in bank 1
      dest = ns'(1);
    end else if (single_bank) begin
      dest = '0;
    end else if (req_addr < bank_limit) begin
      dest = '0;
    end else begin
      dest = ns'(1);
    end
  end

  // ====================
  // message packing
  // ====================
  // core id replaces the opaque high bits so the reply can find its way back
  always_comb begin
    ctrl.op     = req_op;
    ctrl.opaque = {src_id, req_opaque[mo-ns-1:0]};
    ctrl.addr   = req_addr;
    ctrl.domain = req_domain;
  end

  // request struct fills the payload exactly
  assign payload = ctrl;

  assign chan.hdr.dest    = dest;
  assign chan.hdr.src     = src_id;
  assign chan.hdr.payload = payload;

  // data goes on its own lane, untouched
  assign chan.data = req_data;

  // flag a decodable opcode, the bank refuses anything else
  assign chan.load = (req_op == mem_msg_pkg::mem_rd) ||
                     (req_op == mem_msg_pkg::mem_wr) ||
                     (req_op == mem_msg_pkg::mem_dirmem);

endmodule

//--- source/mem_resp_to_net.sv
/* combinational response adapter; routes on the opaque high bits
   outputs read zero while the bank has no valid response */

`timescale 1ns/1ps

`include "mem_net_config.svh"

module mem_resp_to_net (
  net_chan_if.dst                       resp_chan,
  output net_msg_pkg::net_hdr_t         net_hdr,
  output logic [`MEM_DATA_NBITS-1:0]    net_data
);

  localparam int ns = `NET_SRCDEST_NBITS;
  localparam int mo = `MEM_OPAQUE_NBITS;
  localparam int rb = net_msg_pkg::resp_payload_nbits;

  mem_msg_pkg::mem_resp_ctrl_t  in_ctrl;
  mem_msg_pkg::mem_resp_ctrl_t  out_ctrl;
  logic [ns-1:0]                dest;

  // bank reply sits in the low payload bits
  assign in_ctrl = mem_msg_pkg::mem_resp_ctrl_t'(resp_chan.hdr.payload[rb-1:0]);

  // the requesting core was stashed in the opaque high bits
  assign dest = in_ctrl.opaque[mo-1 -: ns];

  always_comb begin
    // routing bits are consumed here, the core only sees its own low bits
    out_ctrl = in_ctrl;
    out_ctrl.opaque[mo-1 -: ns] = '0;

    net_hdr = '0;
    if (resp_chan.load) begin
      net_hdr.dest = dest;
      // src is the answering bank
      net_hdr.src = resp_chan.hdr.src;
      // domain and fail end up above op and opaque through the struct layout
      net_hdr.payload[rb-1:0] = out_ctrl;
    end
  end

  assign net_data = resp_chan.load ? resp_chan.data : '0;

endmodule

//--- source/secure_bank.sv
/* two word-addressed banks behind one port with no byte enables or bursts
   only dest bit 0 picks the bank and memory contents are not reset */

`timescale 1ns/1ps

`include "mem_net_config.svh"

module secure_bank (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue_en,
  input  logic      access_en,
  net_chan_if.dst   req_chan,
  net_chan_if.src   resp_chan
);

  localparam int ns = `NET_SRCDEST_NBITS;
  localparam int dw = `MEM_DATA_NBITS;
  localparam int iw = $clog2(`BANK_WORDS);
  localparam int qb = net_msg_pkg::req_payload_nbits;
  localparam int rb = net_msg_pkg::resp_payload_nbits;

  // bank 0 and bank 1
  logic [dw-1:0] mem [0:1][0:`BANK_WORDS-1];

  // latched request
  net_msg_pkg::net_hdr_t        req_hdr_q;
  logic [dw-1:0]                req_data_q;
  logic                         req_ok_q;
  mem_msg_pkg::mem_req_ctrl_t   req_ctrl;

  // decoded access
  logic                         bank_sel;
  logic [iw-1:0]                word_idx;
  logic                         deny;
  logic                         is_write;

  // registered response
  mem_msg_pkg::mem_resp_ctrl_t  resp_ctrl_q;
  logic [dw-1:0]                resp_data_q;
  logic [ns-1:0]                resp_src_q;
  logic                         resp_valid_q;
  net_msg_pkg::net_hdr_t        resp_hdr;

  // ====================
  // request capture
  // ====================
  always_ff @(posedge clk) begin
    if (issue_en) begin
      req_hdr_q  <= req_chan.hdr;
      req_data_q <= req_chan.data;
    end
  end

  assign req_ctrl = mem_msg_pkg::mem_req_ctrl_t'(req_hdr_q.payload[qb-1:0]);

  assign bank_sel = req_hdr_q.dest[0];
  assign word_idx = req_ctrl.addr[iw+1:2];
  assign is_write = (req_ctrl.op == mem_msg_pkg::mem_wr);

  // non-secure callers may not touch the secure region
  // an undecodable opcode is refused the same way
  assign deny = (!req_ctrl.domain && (req_ctrl.addr >= `SECURE_BASE)) || !req_ok_q;

  // ====================
  // access
  // ====================
  always_ff @(posedge clk) begin
    if (access_en && is_write && !deny) begin
      mem[bank_sel][word_idx] <= req_data_q;
    end
  end

  always_ff @(posedge clk) begin
    if (access_en) begin
      resp_ctrl_q.domain <= req_ctrl.domain;
      resp_ctrl_q.fail   <= deny;
      resp_ctrl_q.op     <= req_ctrl.op;
      // opaque goes back as received with its routing bits
      resp_ctrl_q.opaque <= req_ctrl.opaque;
      // writes and refused reads answer with zero
      if (is_write || deny) begin
        resp_data_q <= '0;
      end else begin
        resp_data_q <= mem[bank_sel][word_idx];
      end
      resp_src_q  <= ns'(bank_sel);
    end
  end

  // response valid from access until the next issue
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_ok_q     <= 1'b0;
      resp_valid_q <= 1'b0;
    end else if (issue_en) begin
      req_ok_q     <= req_chan.load;
      resp_valid_q <= 1'b0;
    end else if (access_en) begin
      resp_valid_q <= 1'b1;
    end
  end

  // ====================
  // response channel
  // ====================
  // the reply routes on the opaque high bits so dest stays zero
  always_comb begin
    resp_hdr = '0;
    resp_hdr.src  = resp_src_q;
    resp_hdr.payload[rb-1:0] = resp_ctrl_q;
  end

  assign resp_chan.hdr  = resp_hdr;
  assign resp_chan.data = resp_data_q;
  assign resp_chan.load = resp_valid_q;

endmodule

//--- source/mem_net_ctrl.sv
/* sequencer for one request at a time; req must follow four-phase rules
   a new request is only taken after ack has dropped */

`timescale 1ns/1ps

module mem_net_ctrl (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req,
  output logic  ack,
  output logic  issue_en,
  output logic  access_en,
  output logic  resp_en
);

  net_msg_pkg::ctrl_state_e state;

  // ====================
  // state machine
  // ====================
  // idle    wait for req
  // issue   bank latches the request message
  // access  bank reads or writes
  // respond output registers load, then hold ack until req drops
  // release one dead cycle before the next request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= net_msg_pkg::st_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        net_msg_pkg::st_idle: begin
          if (req) begin
            state <= net_msg_pkg::st_issue;
          end
        end
        net_msg_pkg::st_issue: begin
          state <= net_msg_pkg::st_access;
        end
        net_msg_pkg::st_access: begin
          state <= net_msg_pkg::st_respond;
        end
        net_msg_pkg::st_respond: begin
          // first cycle here loads the outputs, ack follows on the same edge
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= net_msg_pkg::st_release;
          end
        end
        net_msg_pkg::st_release: begin
          state <= net_msg_pkg::st_idle;
        end
        default: begin
          state <= net_msg_pkg::st_idle;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // ====================
  // datapath strobes
  // ====================
  // each is high for exactly one cycle per request
  assign issue_en  = (state == net_msg_pkg::st_issue);
  assign access_en = (state == net_msg_pkg::st_access);
  // ack low marks the first respond cycle, later cycles only hold
  assign resp_en   = (state == net_msg_pkg::st_respond) && !ack;

endmodule

//--- source/mem_net_top.sv
/* single-core slice of the memory network; ack rises three edges after req
   resp_opaque returns only the low opaque bits, the high bits read zero */

`timescale 1ns/1ps

`include "mem_net_config.svh"

module mem_net_top #(
  parameter int core_id = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mode,
  // core request side
  input  logic                          req,
  input  mem_msg_pkg::mem_op_e          req_op,
  input  logic [`MEM_OPAQUE_NBITS-1:0]  req_opaque,
  input  logic [`MEM_ADDR_NBITS-1:0]    req_addr,
  input  logic [`MEM_DATA_NBITS-1:0]    req_data,
  input  logic                          req_domain,
  output logic                          ack,
  // core response side
  output logic [`MEM_DATA_NBITS-1:0]    resp_data,
  output logic [`MEM_OPAQUE_NBITS-1:0]  resp_opaque,
  output logic [`NET_SRCDEST_NBITS-1:0] resp_src,
  output logic                          resp_domain,
  output logic                          resp_fail
);

  localparam int rb = net_msg_pkg::resp_payload_nbits;

  logic                         issue_en;
  logic                         access_en;
  logic                         resp_en;
  net_msg_pkg::net_hdr_t        net_hdr;
  logic [`MEM_DATA_NBITS-1:0]   net_data;
  mem_msg_pkg::mem_resp_ctrl_t  net_ctrl;

  net_chan_if req_chan ();
  net_chan_if resp_chan ();

  // ====================
  // sequencing
  // ====================
  mem_net_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .issue_en  (issue_en),
    .access_en (access_en),
    .resp_en   (resp_en)
  );

  // ====================
  // request path
  // ====================
  mem_req_to_net #(
    .net_src (core_id)
  ) u_req_to_net (
    .mode       (mode),
    .req_op     (req_op),
    .req_opaque (req_opaque),
    .req_addr   (req_addr),
    .req_data   (req_data),
    .req_domain (req_domain),
    .chan       (req_chan.src)
  );

  secure_bank u_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue_en  (issue_en),
    .access_en (access_en),
    .req_chan  (req_chan.dst),
    .resp_chan (resp_chan.src)
  );

  // ====================
  // response path
  // ====================
  mem_resp_to_net u_resp_to_net (
    .resp_chan (resp_chan.dst),
    .net_hdr   (net_hdr),
    .net_data  (net_data)
  );

  assign net_ctrl = mem_msg_pkg::mem_resp_ctrl_t'(net_hdr.payload[rb-1:0]);

  // outputs hold steady from ack high until the next request responds
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_data   <= '0;
      resp_opaque <= '0;
      resp_src    <= '0;
      resp_domain <= 1'b0;
      resp_fail   <= 1'b0;
    end else if (resp_en) begin
      resp_data   <= net_data;
      resp_opaque <= net_ctrl.opaque;
      // bank id that answered
      resp_src    <= net_hdr.src;
      resp_domain <= net_ctrl.domain;
      resp_fail   <= net_ctrl.fail;
    end
  end

endmodule

//--- tests/mem_net_tb.sv
/* table-driven testbench for mem_net_top with core_id 5
   every read in the table follows a write to the same bank word */

`timescale 1ns/1ps

`include "mem_net_config.svh"

module mem_net_tb;

  localparam int core_id = 5;
  localparam int n_entries = 24;
  localparam int n_passes = 2;
  localparam int cycle_limit = n_entries * n_passes * 10 + 50;
  localparam int mo = `MEM_OPAQUE_NBITS;
  localparam int ns = `NET_SRCDEST_NBITS;

  typedef struct packed {
    logic                         mode;
    mem_msg_pkg::mem_op_e         op;
    logic [`MEM_ADDR_NBITS-1:0]   addr;
    logic [`MEM_DATA_NBITS-1:0]   data;
    logic                         domain;
    logic [`MEM_OPAQUE_NBITS-1:0] opaque;
  } entry_t;

  // ====================
  // stimulus table
  // ====================
  // mode, op, addr, data, domain, opaque
  localparam entry_t stim [n_entries] = '{
    '{1'b0, mem_msg_pkg::mem_wr,     32'h0000_0100, 32'hA1A1_0001, 1'b0, 8'hE1},
    '{1'b0, mem_msg_pkg::mem_rd,     32'h0000_0100, 32'h0000_0000, 1'b0, 8'h02},
    // instruction-mode split point
    '{1'b0, mem_msg_pkg::mem_wr,     32'h0000_3FFC, 32'hA1A1_3FFC, 1'b0, 8'h23},
    '{1'b0, mem_msg_pkg::mem_rd,     32'h0000_3FFC, 32'h0000_0000, 1'b0, 8'hC4},
    '{1'b0, mem_msg_pkg::mem_wr,     32'h0000_4000, 32'hB1B1_4000, 1'b0, 8'h05},
    '{1'b0, mem_msg_pkg::mem_rd,     32'h0000_4000, 32'h0000_0000, 1'b0, 8'hA6},
    // data-mode split point in the secure domain since both sit above the secure base
    '{1'b1, mem_msg_pkg::mem_wr,     32'h0000_BFFC, 32'hA2A2_BFFC, 1'b1, 8'h07},
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_BFFC, 32'h0000_0000, 1'b1, 8'hF8},
    '{1'b1, mem_msg_pkg::mem_wr,     32'h0000_C000, 32'hB2B2_C000, 1'b1, 8'h09},
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_C000, 32'h0000_0000, 1'b1, 8'h6A},
    // 0x3FFC in data mode hits the bank word written at 0xBFFC
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_3FFC, 32'h0000_0000, 1'b0, 8'h0B},
    // dirmem always lands in bank 1
    '{1'b0, mem_msg_pkg::mem_dirmem, 32'h0000_4000, 32'h0000_0000, 1'b0, 8'h8C},
    '{1'b0, mem_msg_pkg::mem_wr,     32'h0000_4100, 32'hB3B3_4100, 1'b0, 8'h0D},
    '{1'b1, mem_msg_pkg::mem_dirmem, 32'h0000_0100, 32'h0000_0000, 1'b0, 8'h3E},
    // secure region
    '{1'b1, mem_msg_pkg::mem_wr,     32'h0000_8010, 32'h5EC0_0001, 1'b1, 8'h0F},
    '{1'b1, mem_msg_pkg::mem_wr,     32'h0000_8010, 32'hBAD0_0BAD, 1'b0, 8'h90},
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_8010, 32'h0000_0000, 1'b0, 8'h11},
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_8010, 32'h0000_0000, 1'b1, 8'hD2},
    '{1'b0, mem_msg_pkg::mem_wr,     32'h0000_9000, 32'h5EC0_9000, 1'b1, 8'h13},
    '{1'b0, mem_msg_pkg::mem_rd,     32'h0000_9000, 32'h0000_0000, 1'b0, 8'h74},
    '{1'b0, mem_msg_pkg::mem_rd,     32'h0000_9000, 32'h0000_0000, 1'b1, 8'h15},
    '{1'b0, mem_msg_pkg::mem_dirmem, 32'h0000_8000, 32'h0000_0000, 1'b0, 8'hB6},
    // just below the secure base where any domain may write
    '{1'b1, mem_msg_pkg::mem_wr,     32'h0000_7FFC, 32'h7FFC_7FFC, 1'b0, 8'h17},
    '{1'b1, mem_msg_pkg::mem_rd,     32'h0000_7FFC, 32'h0000_0000, 1'b0, 8'h58}
  };

  logic                          clk;
  logic                          rst_n;
  logic                          mode;
  logic                          req;
  mem_msg_pkg::mem_op_e          req_op;
  logic [`MEM_OPAQUE_NBITS-1:0]  req_opaque;
  logic [`MEM_ADDR_NBITS-1:0]    req_addr;
  logic [`MEM_DATA_NBITS-1:0]    req_data;
  logic                          req_domain;
  logic                          ack;
  logic [`MEM_DATA_NBITS-1:0]    resp_data;
  logic [`MEM_OPAQUE_NBITS-1:0]  resp_opaque;
  logic [`NET_SRCDEST_NBITS-1:0] resp_src;
  logic                          resp_domain;
  logic                          resp_fail;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  integer seed = 14112;
  // reference store keyed by bank * BANK_WORDS + word index
  logic [`MEM_DATA_NBITS-1:0] ref_mem [int];

  mem_net_top #(
    .core_id (core_id)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .req         (req),
    .req_op      (req_op),
    .req_opaque  (req_opaque),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .req_domain  (req_domain),
    .ack         (ack),
    .resp_data   (resp_data),
    .resp_opaque (resp_opaque),
    .resp_src    (resp_src),
    .resp_domain (resp_domain),
    .resp_fail   (resp_fail)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20;
      clk = ~clk;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ====================
  // reference rules
  // ====================
  function automatic logic [ns-1:0] route_bank(input logic m, input mem_msg_pkg::mem_op_e op,
                                               input logic [`MEM_ADDR_NBITS-1:0] a);
    logic [`MEM_ADDR_NBITS-1:0] limit;
    limit = m ? `DATA_BANK_LIMIT : `INST_BANK_LIMIT;
    if (op == mem_msg_pkg::mem_dirmem) begin
      return 1;
    end
    if (`SINGLE_BANK != 0) begin
      return 0;
    end
    return (a < limit) ? 0 : 1;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp,
                           input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s is 0x%0h, expected 0x%0h (entry %0d)", $time, what, got, exp, idx);
    end
  endtask

  // one full four-phase transfer with req held for hold extra cycles after ack
  task automatic run_entry(input entry_t e, input int idx, input int hold);
    logic [ns-1:0]              bank;
    logic                       fail;
    int                         key;
    logic                       have_data;
    logic [`MEM_DATA_NBITS-1:0] exp_data;
    logic [mo-1:0]              exp_opaque;
    int                         edges;
    logic [63:0]                snap;
    bank = route_bank(e.mode, e.op, e.addr);
    fail = !e.domain && (e.addr >= `SECURE_BASE);
    key = int'(bank) * `BANK_WORDS + int'(e.addr[9:2]);
    exp_opaque = e.opaque;
    exp_opaque[mo-1 -: ns] = '0;
    have_data = 1'b0;
    exp_data = '0;
    if (e.op != mem_msg_pkg::mem_wr) begin
      if (fail) begin
        have_data = 1'b1;
      end else if (ref_mem.exists(key)) begin
        have_data = 1'b1;
        exp_data = ref_mem[key];
      end
    end else if (!fail) begin
      ref_mem[key] = e.data;
    end

    @(posedge clk);
    #2;
    mode = e.mode;
    req_op = e.op;
    req_opaque = e.opaque;
    req_addr = e.addr;
    req_data = e.data;
    req_domain = e.domain;
    req = 1'b1;

    // this edge samples req and starts the edge count
    @(posedge clk);
    edges = 0;
    while (!ack && edges < 8) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (!ack) begin
      errors++;
      $display("entry %0d got no ack within 8 cycles of the request", idx);
    end else begin
      check_val("ack latency", edges, 3, idx);
      if (have_data) begin
        check_val("resp_data", resp_data, exp_data, idx);
      end
      check_val("resp_src", resp_src, bank, idx);
      check_val("resp_fail", resp_fail, fail, idx);
      check_val("resp_domain", resp_domain, e.domain, idx);
      check_val("resp_opaque", resp_opaque, exp_opaque, idx);
    end

    // ack and outputs hold still under back-pressure
    snap = {resp_data, resp_opaque, resp_src, resp_domain, resp_fail};
    repeat (hold) begin
      @(posedge clk);
      #1;
      checks++;
      if (!ack || snap != {resp_data, resp_opaque, resp_src, resp_domain, resp_fail}) begin
        errors++;
        $display("ERROR %0t: ack or outputs moved while req held (entry %0d)", $time, idx);
      end
    end

    #1;
    req = 1'b0;
    edges = 0;
    while (ack && edges < 8) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (ack) begin
      errors++;
      $display("entry %0d: ack stayed high after req was dropped", idx);
    end else begin
      check_val("ack release latency", edges, 1, idx);
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    entry_t e;
    logic [31:0] rnd;
    rst_n = 1'b0;
    req = 1'b0;
    mode = 1'b0;
    req_op = mem_msg_pkg::mem_rd;
    req_opaque = '0;
    req_addr = '0;
    req_data = '0;
    req_domain = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_val("ack after reset", ack, 0, -1);
    check_val("resp_data after reset", resp_data, 0, -1);
    check_val("resp_opaque after reset", resp_opaque, 0, -1);
    check_val("resp_src after reset", resp_src, 0, -1);
    check_val("resp_domain after reset", resp_domain, 0, -1);
    check_val("resp_fail after reset", resp_fail, 0, -1);

    for (int i = 0; i < n_entries; i++) begin
      run_entry(stim[i], i, i % 3);
    end

    // same addresses again with fresh data and opaque low bits
    for (int i = 0; i < n_entries; i++) begin
      e = stim[i];
      rnd = $random(seed);
      e.data = rnd;
      rnd = $random(seed);
      e.opaque[mo-ns-1:0] = rnd[mo-ns-1:0];
      run_entry(e, n_entries + i, (i + 1) % 3);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- mem_net.f
+incdir+source
source/mem_msg_pkg.sv
source/net_msg_pkg.sv
source/net_chan_if.sv
source/mem_req_to_net.sv
source/mem_resp_to_net.sv
source/secure_bank.sv
source/mem_net_ctrl.sv
source/mem_net_top.sv
tests/mem_net_tb.sv

//--- Bender.yml
package:
  name: mem_net

sources:
  - include_dirs:
      - source
    files:
      - source/mem_msg_pkg.sv
      - source/net_msg_pkg.sv
      - source/net_chan_if.sv
      - source/mem_req_to_net.sv
      - source/mem_resp_to_net.sv
      - source/secure_bank.sv
      - source/mem_net_ctrl.sv
      - source/mem_net_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/mem_net_tb.sv
